// ==== src.f ====
+incdir+hw
hw/cpuSmPkg.sv
hw/cpuSmInputs.sv
hw/cpuSmCore.sv
hw/dmaFifo.sv
hw/cpuDataPath.sv
hw/cpuSm.sv
testbench/cpuSmTb.sv

// ==== testbench/cpuSmTb.sv ====
`timescale 1ns/100ps
`include "cpuSmMacros.svh"

module cpuSmTb;

  logic               clk, rstN;
  logic               sPush, sPop, dmaEna, dmaDir, flushFifo, boEq3;
  logic [31:0]        sPushData, sPopData, dataOut;
  logic               fifoFull, fifoEmpty, brN, bgackN, rwN, asN, dsN;
  logic [`ADDR_W-1:0] startAddr, addr;
  logic               bgN = 1'b1;       // memory and arbiter side
  logic               dsack0N = 1'b1;
  logic               dsack1N = 1'b1;
  logic [31:0]        dataIn = '0;

  logic [31:0] lfsr = 32'hbc6b_998c;
  logic [31:0] words [`FIFO_DEPTH];     // words pushed in the current test
  logic [1:0]  waits [64];              // acknowledge delays
  logic [15:0] mem [256];               // big endian halfword memory
  logic [31:0] logAddr [256];           // completed bus cycles
  logic [31:0] logData [256];
  int          logWr = 0;
  int          logRd = 0;
  int          popRd = 0;
  int          cycBase, popBase, waitCnt;
  bit          port16, inCycle;
  logic [7:0]  memIdx;
  logic [63:0] expCycle;
  string       testName;

  cpuSm UUT (
    .clk(clk), .rstN(rstN), .sPush(sPush), .sPushData(sPushData), .sPop(sPop),
    .sPopData(sPopData), .fifoFull(fifoFull), .fifoEmpty(fifoEmpty),
    .dmaEna(dmaEna), .dmaDir(dmaDir), .flushFifo(flushFifo), .boEq3(boEq3),
    .startAddr(startAddr), .brN(brN), .bgN(bgN), .bgackN(bgackN), .addr(addr),
    .rwN(rwN), .asN(asN), .dsN(dsN), .dataOut(dataOut), .dataIn(dataIn),
    .dsack0N(dsack0N), .dsack1N(dsack1N)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
    return r;
  endfunction

  function automatic logic [15:0] fillHalf(input logic [31:0] a);
    logic [31:0] p;
    p = (a >> 1) * 32'h0000_9e37 + 32'h5a3c;
    return p[15:0] ^ p[31:16];
  endfunction

  // long word n as pushed or as first filled in memory
  function automatic logic [31:0] expectedWord(input int n);
    logic [31:0] a;
    a = startAddr + 32'(4 * n);
    if (dmaDir) return words[n];
    return {fillHalf(a), fillHalf(a + 32'd2)};
  endfunction

  // address and lane data of bus cycle k
  function automatic logic [63:0] expectedCycle(input int k);
    int          n;
    logic [31:0] a, w;
    n = port16 ? k / 2 : k;
    a = startAddr + 32'(4 * n);
    w = expectedWord(n);
    if (port16 && k % 2 == 1) begin
      a = a + 32'd2;
      w = {w[15:0], 16'h0000};   // lower half rides D31..D16
    end else if (port16) begin
      w = {w[31:16], 16'h0000};
    end
    return {a, w};
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s %s: expected %h, actual %h", testName, what, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("timeout in test %s: %s", testName, what);
    $display("*** FAILED ***");
    $fatal(1, "wait timed out");
  endtask

  initial begin
    for (int i = 0; i < 256; i++) mem[i] = fillHalf(32'(i) << 1);
  end

  // memory model acknowledges after a random wait
  always @(negedge clk) begin
    if (asN !== 1'b0) begin
      dsack0N = 1'b1;
      dsack1N = 1'b1;
      inCycle = 1'b0;
    end else if (dsack1N) begin
      if (!inCycle) begin
        inCycle = 1'b1;
        waitCnt = waits[logWr % 64];
        checkValue("dsN", 32'd0, dsN);
        checkValue("bgackN", 32'd0, bgackN);
      end
      if (waitCnt != 0) begin
        waitCnt--;
      end else begin
        memIdx = addr[8:1];
        if (!rwN) begin
          mem[memIdx] = dataOut[31:16];
          if (!port16) mem[memIdx + 1] = dataOut[15:0];
        end
        dataIn = port16 ? {mem[memIdx], ~mem[memIdx]} : {mem[memIdx], mem[memIdx + 1]};
        logAddr[logWr] = addr;
        logData[logWr] = port16 ? {mem[memIdx], 16'h0000} : dataIn;
        logWr++;
        dsack1N = 1'b0;
        dsack0N = port16;   // 16-bit port answers on dsack1N alone
      end
    end
    bgN = brN;   // grant one half cycle after request
  end

  // compare process
  always @(posedge clk) begin
    if (logRd != logWr) begin
      expCycle = expectedCycle(logRd - cycBase);
      checkValue("bus address", expCycle[63:32], logAddr[logRd]);
      checkValue("bus data", expCycle[31:0], logData[logRd]);
      logRd++;
    end
    if (sPop) begin
      checkValue("popped word", expectedWord(popRd - popBase), sPopData);
      popRd++;
    end
  end

  task automatic beginTest(input string name, input bit dir, input bit p16,
                           input logic [31:0] a);
    testName = name;
    dmaDir = dir;
    port16 = p16;
    startAddr = a;
    cycBase = logRd;
    popBase = popRd;
  endtask

  task automatic pushWords(input int n, input bit idleCheck);
    int t;
    for (int i = 0; i < n; i++) begin
      t = 0;
      while (fifoFull) begin
        @(negedge clk);
        t++;
        if (t > 200) reportTimeout("FIFO stayed full");
      end
      words[i] = randBits(32);
      sPushData = words[i];
      sPush = 1'b1;
      @(negedge clk);
      sPush = 1'b0;
      if (idleCheck) checkValue("brN", 32'd1, brN);
    end
  endtask

  task automatic popWords(input int n);
    int t;
    for (int i = 0; i < n; i++) begin
      t = 0;
      while (fifoEmpty) begin
        @(negedge clk);
        t++;
        if (t > 200) reportTimeout("FIFO stayed empty");
      end
      sPop = 1'b1;
      @(negedge clk);
      sPop = 1'b0;
    end
  endtask

  // n bus cycles done and bus released
  task automatic waitTransfer(input int n);
    int t;
    t = 0;
    while (logRd != cycBase + n || !brN) begin
      @(negedge clk);
      t++;
      if (t > 2000) reportTimeout("bus transfer did not finish");
    end
    repeat (2) @(negedge clk);
    checkValue("bus cycles", n, logRd - cycBase);
  endtask

  task automatic readTest(input int nCycles);
    dmaEna = 1'b1;
    waitTransfer(nCycles);
    checkValue("fifoFull", 32'd1, fifoFull);
    dmaEna = 1'b0;
    popWords(`FIFO_DEPTH);
    checkValue("fifoEmpty", 32'd1, fifoEmpty);
  endtask

  initial begin
    rstN = 1'b0;
    sPush = 1'b0;
    sPushData = '0;
    sPop = 1'b0;
    dmaEna = 1'b0;
    dmaDir = 1'b1;
    flushFifo = 1'b0;
    boEq3 = 1'b0;
    startAddr = '0;
    for (int i = 0; i < 64; i++) waits[i] = 2'(randBits(2));
    repeat (3) @(negedge clk);
    rstN = 1'b1;
    beginTest("reset", 1'b1, 1'b0, 32'h0);
    checkValue("brN", 32'd1, brN);
    checkValue("bgackN", 32'd1, bgackN);
    checkValue("asN", 32'd1, asN);
    checkValue("dsN", 32'd1, dsN);
    checkValue("fifoEmpty", 32'd1, fifoEmpty);

    beginTest("noEnable", 1'b1, 1'b0, 32'h40);   // fill with transfers off
    pushWords(`FIFO_DEPTH, 1'b1);
    repeat (4) begin
      @(negedge clk);
      checkValue("brN", 32'd1, brN);
    end
    checkValue("fifoFull", 32'd1, fifoFull);

    beginTest("write32", 1'b1, 1'b0, 32'h40);
    dmaEna = 1'b1;
    waitTransfer(`FIFO_DEPTH);
    checkValue("fifoEmpty", 32'd1, fifoEmpty);

    beginTest("write16", 1'b1, 1'b1, 32'h80);
    pushWords(`FIFO_DEPTH, 1'b0);
    waitTransfer(2 * `FIFO_DEPTH);
    checkValue("fifoEmpty", 32'd1, fifoEmpty);

    beginTest("flush", 1'b1, 1'b0, 32'h100);
    dmaEna = 1'b0;
    flushFifo = 1'b1;
    pushWords(3, 1'b1);
    dmaEna = 1'b1;
    waitTransfer(3);
    checkValue("fifoEmpty", 32'd1, fifoEmpty);
    checkValue("brN", 32'd1, brN);
    flushFifo = 1'b0;
    dmaEna = 1'b0;

    beginTest("read32", 1'b0, 1'b0, 32'h140);
    readTest(`FIFO_DEPTH);
    beginTest("read16", 1'b0, 1'b1, 32'h180);
    readTest(2 * `FIFO_DEPTH);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== hw/cpuSm.sv ====
`timescale 1ns/100ps
`include "cpuSmMacros.svh"

module cpuSm import cpuSmPkg::*; (
  input  logic               clk,
  input  logic               rstN,
  input  logic               sPush,
  input  logic [31:0]        sPushData,
  input  logic               sPop,
  output logic [31:0]        sPopData,
  output logic               fifoFull,
  output logic               fifoEmpty,
  input  logic               dmaEna,
  input  logic               dmaDir,
  input  logic               flushFifo,
  input  logic               boEq3,
  input  logic [`ADDR_W-1:0] startAddr,
  output logic               brN,
  input  logic               bgN,
  output logic               bgackN,
  output logic [`ADDR_W-1:0] addr,
  output logic               rwN,
  output logic               asN,
  output logic               dsN,
  output logic [31:0]        dataOut,
  input  logic [31:0]        dataIn,
  input  logic               dsack0N,
  input  logic               dsack1N
);

  logic [`STATE_W-1:0] state;
  logic [`TERM_W-1:0]  terms;
  logic                dreqN, cycleDone, a1, lastWord;
  logic                fifoRd, fifoWr, halfSel, addrInc;
  logic                push, pop, latchHalf;
  busWordT             pushData, popData, readWord, busOut;

  // FIFO ports follow the transfer direction
  assign push     = dmaDir ? sPush : fifoWr;
  assign pop      = dmaDir ? fifoRd : sPop;
  assign pushData = dmaDir ? busWordT'(sPushData) : readWord;
  assign sPopData = popData.whole;
  assign dataOut  = busOut.whole;

  assign latchHalf = ~asN & rwN & ~dsack1N;   // read data valid with acknowledge

  cpuSmInputs uInputs (
    .state(state), .a1(a1), .bgN(bgN), .boEq3(boEq3), .cycleDone(cycleDone),
    .dmaDir(dmaDir), .dmaEna(dmaEna), .dreqN(dreqN), .dsack0N(dsack0N),
    .dsack1N(dsack1N), .fifoEmpty(fifoEmpty), .fifoFull(fifoFull),
    .flushFifo(flushFifo), .lastWord(lastWord), .terms(terms)
  );

  cpuSmCore uCore (
    .clk(clk), .rstN(rstN), .terms(terms), .state(state), .dreqN(dreqN),
    .cycleDone(cycleDone), .brN(brN), .bgackN(bgackN), .asN(asN), .dsN(dsN),
    .rwN(rwN), .fifoRd(fifoRd), .fifoWr(fifoWr), .halfSel(halfSel),
    .addrInc(addrInc)
  );

  dmaFifo uFifo (
    .clk(clk), .rstN(rstN), .push(push), .pushData(pushData), .pop(pop),
    .popData(popData), .full(fifoFull), .empty(fifoEmpty), .lastWord(lastWord)
  );

  cpuDataPath uDataPath (
    .clk(clk), .rstN(rstN), .startAddr(startAddr), .load(state == '0),
    .addrInc(addrInc), .halfSel(halfSel), .fifoWord(popData),
    .dataIn(busWordT'(dataIn)), .latchHalf(latchHalf), .addr(addr), .a1(a1),
    .dataOut(busOut), .readWord(readWord)
  );
endmodule

// ==== hw/cpuDataPath.sv ====
`timescale 1ns/100ps
`include "cpuSmMacros.svh"

module cpuDataPath import cpuSmPkg::*; (
  input  logic               clk,
  input  logic               rstN,
  input  logic [`ADDR_W-1:0] startAddr,
  input  logic               load,
  input  logic               addrInc,
  input  logic               halfSel,
  input  busWordT            fifoWord,
  input  busWordT            dataIn,
  input  logic               latchHalf,
  output logic [`ADDR_W-1:0] addr,
  output logic               a1,
  output busWordT            dataOut,
  output busWordT            readWord
);

  logic [`ADDR_W-1:0] addrReg;

  always_ff @(posedge clk) begin
    if (!rstN)        addrReg <= '0;
    else if (load)    addrReg <= startAddr;
    else if (addrInc) addrReg <= addrReg + `ADDR_W'd4;   // next long word
  end

  // lower half cycle of a 16-bit port sets A1
  assign addr = {addrReg[`ADDR_W-1:2], addrReg[1] | halfSel, addrReg[0]};
  assign a1   = addr[1];

  always_comb begin
    if (halfSel) begin
      dataOut.half.upper = fifoWord.half.lower;   // 16-bit port lane
      dataOut.half.lower = fifoWord.half.lower;
    end else begin
      dataOut.whole = fifoWord.whole;
    end
  end

  // first cycle takes the whole bus, a lower half cycle patches the low half
  always_ff @(posedge clk) begin
    if (latchHalf) begin
      if (halfSel) readWord.half.lower <= dataIn.half.upper;
      else         readWord.whole      <= dataIn.whole;
    end
  end
endmodule

// ==== hw/dmaFifo.sv ====
`timescale 1ns/100ps
`include "cpuSmMacros.svh"

module dmaFifo import cpuSmPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    push,
  input  busWordT pushData,
  input  logic    pop,
  output busWordT popData,
  output logic    full,
  output logic    empty,
  output logic    lastWord
);

  localparam int ptrW = $clog2(`FIFO_DEPTH);

  busWordT         mem [`FIFO_DEPTH];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   count;

  always_ff @(posedge clk) begin
    if (push) mem[wrPtr] <= pushData;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= wrPtr + 1'b1;   // depth is a power of two
      if (pop)  rdPtr <= rdPtr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign popData  = mem[rdPtr];   // head word
  assign full     = (count == `FIFO_DEPTH);
  assign empty    = (count == '0);
  assign lastWord = (count == 1);
endmodule

// ==== hw/cpuSmCore.sv ====
`timescale 1ns/100ps
`include "cpuSmMacros.svh"

module cpuSmCore (
  input  logic                clk,
  input  logic                rstN,
  input  logic [`TERM_W-1:0]  terms,
  output logic [`STATE_W-1:0] state,
  output logic                dreqN,
  output logic                cycleDone,
  output logic                brN,
  output logic                bgackN,
  output logic                asN,
  output logic                dsN,
  output logic                rwN,
  output logic                fifoRd,
  output logic                fifoWr,
  output logic                halfSel,
  output logic                addrInc
);

  localparam int numTerms = 22;

  localparam logic [`STATE_W-1:0] sIdle      = 5'd0;
  localparam logic [`STATE_W-1:0] sWrStrobe  = 5'd1;
  localparam logic [`STATE_W-1:0] sWrReq     = 5'd2;
  localparam logic [`STATE_W-1:0] sWrRelease = 5'd3;
  localparam logic [`STATE_W-1:0] sRdReq     = 5'd4;
  localparam logic [`STATE_W-1:0] sWrHalf    = 5'd5;
  localparam logic [`STATE_W-1:0] sWrLower   = 5'd7;
  localparam logic [`STATE_W-1:0] sWrDone    = 5'd8;
  localparam logic [`STATE_W-1:0] sRdStrobe  = 5'd9;
  localparam logic [`STATE_W-1:0] sRdDone    = 5'd10;
  localparam logic [`STATE_W-1:0] sRdRelease = 5'd11;
  localparam logic [`STATE_W-1:0] sRdCheck   = 5'd12;
  localparam logic [`STATE_W-1:0] sRdHalf    = 5'd13;
  localparam logic [`STATE_W-1:0] sRdLower   = 5'd15;

  // target state of each term, index order sets priority
  localparam logic [`STATE_W-1:0] termTarget [numTerms] = '{
    sWrReq, sWrReq, sWrReq, sRdReq,
    sWrStrobe, sRdStrobe,
    sWrRelease, sWrHalf, sWrLower, sWrRelease, sWrDone, sIdle, sWrStrobe,
    sRdRelease, sRdHalf, sRdLower, sRdRelease, sRdDone, sRdCheck,
    sIdle, sIdle, sRdStrobe
  };

  logic [`STATE_W-1:0] nextState;
  logic                inStrobe;

  // lowest active term index wins
  always_comb begin
    nextState = state;
    for (int i = numTerms - 1; i >= 0; i--) begin
      if (terms[i]) nextState = termTarget[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) state <= sIdle;
    else       state <= nextState;
  end

  assign inStrobe = (state == sWrStrobe) | (state == sWrLower) |
                    (state == sRdStrobe) | (state == sRdLower);

  assign dreqN     = ~((state == sWrReq) | (state == sRdReq));   // own bus request
  assign brN       = (state == sIdle);
  assign bgackN    = (state == sIdle) | (state == sWrReq) | (state == sRdReq);
  assign asN       = ~inStrobe;
  assign dsN       = ~inStrobe;
  // write cycle from first strobe through the pop
  assign rwN       = ~((state == sWrStrobe) | (state == sWrHalf) | (state == sWrLower) |
                       (state == sWrRelease) | (state == sWrDone));
  assign cycleDone = (state == sWrDone) | (state == sRdDone);
  assign fifoRd    = (state == sWrDone);
  assign fifoWr    = (state == sRdDone);
  assign addrInc   = cycleDone;                         // one step per long word
  assign halfSel   = (state == sWrLower) | (state == sRdLower);
endmodule

// ==== hw/cpuSmInputs.sv ====
`timescale 1ns/100ps
`include "cpuSmMacros.svh"

module cpuSmInputs (
  input  logic [`STATE_W-1:0] state,
  input  logic                a1,
  input  logic                bgN,
  input  logic                boEq3,
  input  logic                cycleDone,
  input  logic                dmaDir,
  input  logic                dmaEna,
  input  logic                dreqN,
  input  logic                dsack0N,
  input  logic                dsack1N,
  input  logic                fifoEmpty,
  input  logic                fifoFull,
  input  logic                flushFifo,
  input  logic                lastWord,
  output logic [`TERM_W-1:0]  terms
);

  logic s0, s1, s2, s3, s4, s5, s7, s8;
  logic s9, s10, s11, s12, s13, s15;
  logic ackLong;   // 32-bit port acknowledge
  logic ackHalf;   // 16-bit port acknowledge
  logic ackIdle;   // both acknowledges released

  assign s0  = (state == 5'd0);
  assign s1  = (state == 5'd1);
  assign s2  = (state == 5'd2);
  assign s3  = (state == 5'd3);
  assign s4  = (state == 5'd4);
  assign s5  = (state == 5'd5);
  assign s7  = (state == 5'd7);
  assign s8  = (state == 5'd8);
  assign s9  = (state == 5'd9);
  assign s10 = (state == 5'd10);
  assign s11 = (state == 5'd11);
  assign s12 = (state == 5'd12);
  assign s13 = (state == 5'd13);
  assign s15 = (state == 5'd15);

  assign ackLong = ~dsack0N & ~dsack1N;
  assign ackHalf = dsack0N & ~dsack1N;
  assign ackIdle = dsack0N & dsack1N;

  // idle, write direction
  assign terms[0]  = s0 & dmaEna & dmaDir & fifoFull;                 // s0
  assign terms[1]  = s0 & dmaEna & dmaDir & ~fifoEmpty & flushFifo;   // s0
  assign terms[2]  = s0 & dmaEna & dmaDir & ~fifoEmpty & boEq3;       // s0
  // idle, read direction
  assign terms[3]  = s0 & dmaEna & ~dmaDir & ~fifoFull;               // s0

  // grant seen while requesting
  assign terms[4]  = s2 & ~bgN & ~dreqN;                              // s2
  assign terms[5]  = s4 & ~bgN & ~dreqN;                              // s4

  // write strobes
  assign terms[6]  = s1 & ackLong;                                    // s1
  assign terms[7]  = s1 & ackHalf;                                    // s1
  assign terms[8]  = s5 & ackIdle & ~a1;                              // s5
  assign terms[9]  = s7 & ~dsack1N;                                   // s7
  assign terms[10] = s3 & ackIdle;                                    // s3
  assign terms[11] = s8 & cycleDone & lastWord;                       // s8
  assign terms[12] = s8 & cycleDone & ~lastWord;                      // s8

  // read strobes
  assign terms[13] = s9 & ackLong;                                    // s9
  assign terms[14] = s9 & ackHalf;                                    // s9
  assign terms[15] = s13 & ackIdle & ~a1;                             // s13
  assign terms[16] = s15 & ~dsack1N;                                  // s15
  assign terms[17] = s11 & ackIdle;                                   // s11
  assign terms[18] = s10 & cycleDone;                                 // s10
  assign terms[19] = s12 & fifoFull;                                  // s12
  assign terms[20] = s12 & ~dmaEna;                                   // s12
  assign terms[21] = s12 & dmaEna & ~fifoFull;                        // s12

  assign terms[`TERM_W-1:22] = '0;   // spare terms
endmodule

// ==== hw/cpuSmPkg.sv ====
package cpuSmPkg;

  // one bus word, seen whole or as two 16-bit halves
  typedef union packed {
    logic [31:0] whole;     // 32-bit port view
    struct packed {
      logic [15:0] upper;   // D31..D16, the only lane of a 16-bit port
      logic [15:0] lower;
    } half;
  } busWordT;

endpackage

// ==== hw/cpuSmMacros.svh ====
`ifndef CPU_SM_MACROS_SVH
`define CPU_SM_MACROS_SVH

`define STATE_W 5     // state number width
`define TERM_W 63     // decoded product terms
`define FIFO_DEPTH 8  // long words, 4 or 16 also fine
`define ADDR_W 32     // bus address width

`endif
